// ==== all.f ====
+incdir+include
src/icache_pkg.sv
src/icache_prefetch.sv
src/icache_controller.sv
src/icachemem.sv
src/icache.sv
tests/imem_model.sv
tests/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/icache_pkg.sv
      - src/icache_prefetch.sv
      - src/icache_controller.sv
      - src/icachemem.sv
      - src/icache.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/imem_model.sv
      - tests/icache_tb.sv

// ==== tests/icache_tb.sv ====
`include "icache_settings.svh"

module icache_tb;

	localparam int STIM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES * 4 + 200;
	localparam int MAX_LATENCY = 8;
	localparam int HOLD_LIMIT = MAX_LATENCY * (`ICACHE_PREFETCH_CREDITS + 2);
	localparam int STREAM_TRIALS = 6;
	localparam int STREAM_LEN = 3;
	localparam int TAGS = 1 << `ICACHE_MEM_TAG_BITS;
	localparam logic [31:0] SEED = 32'h487d;
	localparam logic [`ICACHE_ADDR_BITS-1:0] BLOCK_BYTES = 1 << `ICACHE_OFFSET_BITS;
	localparam logic [`ICACHE_ADDR_BITS-1:0] WINDOW_BASE = 64'h0000_0400_0001_0000;

	logic clock;
	logic reset;
	icache_pkg::fetch_req_t req;
	logic mispredict;
	logic [`ICACHE_ADDR_BITS-1:0] target;
	icache_pkg::mem_resp_t mem_in;
	icache_pkg::mem_req_t mem_out;
	icache_pkg::fetch_resp_t resp;
	logic [`ICACHE_ADDR_BITS-1:0] ret_addr;
	logic [`ICACHE_BLOCK_BITS-1:0] ret_data;

	integer seed;
	int cycle_count = 0;
	int hold_cycles;
	int in_flight;
	int stream_events;
	logic answered;
	logic directed;
	logic stream_active;
	logic [`ICACHE_ADDR_BITS-1:0] stream_next;

	// mirror of the line store built from bus traffic
	logic line_valid [`ICACHE_LINES];
	logic line_pending [`ICACHE_LINES];
	logic [`ICACHE_ADDR_BITS-1:0] line_addr [`ICACHE_LINES];
	logic txn_busy [TAGS];
	logic [`ICACHE_ADDR_BITS-1:0] txn_addr [TAGS];

	icache i_icache (
		.clock(clock),
		.reset(reset),
		.req(req),
		.mispredict(mispredict),
		.target(target),
		.mem_in(mem_in),
		.mem_out(mem_out),
		.resp(resp)
	);

	imem_model #(
		.MAX_LATENCY(MAX_LATENCY),
		.SEED(SEED)
	) i_mem_model (
		.clock(clock),
		.reset(reset),
		.mem_out(mem_out),
		.ret_data(ret_data),
		.ret_addr(ret_addr),
		.mem_in(mem_in)
	);

	function automatic logic [`ICACHE_ADDR_BITS-1:0] align_block(
		input logic [`ICACHE_ADDR_BITS-1:0] addr
	);
		return addr & ~(BLOCK_BYTES - 1);
	endfunction

	function automatic int index_of(input logic [`ICACHE_ADDR_BITS-1:0] addr);
		return int'(addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]);
	endfunction

	// memory contents as a fixed scramble of the block address
	function automatic logic [`ICACHE_BLOCK_BITS-1:0] block_data(
		input logic [`ICACHE_ADDR_BITS-1:0] addr
	);
		logic [63:0] a;
		a = align_block(addr);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	function automatic logic block_in_flight(input logic [`ICACHE_ADDR_BITS-1:0] addr);
		for (int t = 1; t < TAGS; t++) begin
			if (txn_busy[t] && txn_addr[t] == align_block(addr)) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// 256 blocks over 32 lines so conflicts are common
	function automatic logic [`ICACHE_ADDR_BITS-1:0] window_addr();
		return WINDOW_BASE + `ICACHE_ADDR_BITS'($unsigned($random(seed)) % 2048);
	endfunction

	assign ret_data = block_data(ret_addr);

	task automatic report_error(input string msg);
		$display("** Error at time %0t: %s", $time, msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_resp(
		input icache_pkg::fetch_resp_t got,
		input icache_pkg::fetch_resp_t exp
	);
		if (got.valid !== exp.valid) begin
			report_error($sformatf("resp.valid is %b, expected %b, address %h",
				got.valid, exp.valid, req.address));
		end else if (exp.valid && got.data !== exp.data) begin
			report_error($sformatf("resp.data is %h, expected %h, address %h",
				got.data, exp.data, req.address));
		end
	endtask

	task automatic check_mem_req(
		input icache_pkg::mem_req_t got,
		input icache_pkg::mem_req_t exp
	);
		if (got.command !== exp.command) begin
			report_error($sformatf("mem_out.command is %0d, expected %0d",
				got.command, exp.command));
		end else if (exp.command == icache_pkg::BUS_LOAD && got.address !== exp.address) begin
			report_error($sformatf("mem_out.address is %h, expected %h",
				got.address, exp.address));
		end
	endtask

	task automatic drive_random();
		int r;
		r = $random(seed);
		mispredict <= ($unsigned(r) % 20) == 0;
		target <= window_addr();
		// keep the address until it has been answered
		if (answered || req.command != icache_pkg::BUS_LOAD) begin
			req.address <= window_addr();
			req.command <= (($random(seed) & 7) == 0) ? icache_pkg::BUS_NONE :
				icache_pkg::BUS_LOAD;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("the run timed out after %0d cycles", cycle_count);
			$display("test failed");
			$fatal(1);
		end
	end

	// checks and mirror update once per cycle at the falling edge
	always @(negedge clock) begin : monitor
		icache_pkg::fetch_resp_t exp_resp;
		icache_pkg::mem_req_t exp_req;
		logic accepted;
		logic [`ICACHE_ADDR_BITS-1:0] blk;
		int idx;
		if (reset) begin
			for (int i = 0; i < `ICACHE_LINES; i++) begin
				line_valid[i] = 1'b0;
				line_pending[i] = 1'b0;
			end
			for (int t = 0; t < TAGS; t++) begin
				txn_busy[t] = 1'b0;
			end
			in_flight = 0;
			hold_cycles = 0;
			answered = 1'b0;
			stream_active = 1'b0;
		end else begin
			blk = align_block(req.address);
			idx = index_of(req.address);
			exp_resp.valid = req.command == icache_pkg::BUS_LOAD && line_valid[idx]
				&& line_addr[idx] == blk && !mispredict;
			exp_resp.data = block_data(blk);
			check_resp(resp, exp_resp);

			answered = resp.valid;
			if (req.command == icache_pkg::BUS_LOAD && !resp.valid) begin
				hold_cycles++;
				if (hold_cycles > HOLD_LIMIT) begin
					report_error($sformatf("no valid result for %h after %0d cycles",
						req.address, hold_cycles));
				end
			end else begin
				hold_cycles = 0;
			end

			accepted = mem_out.command == icache_pkg::BUS_LOAD && mem_in.response != '0;

			// a demand miss on a line that is not pending goes out at once
			if (req.command == icache_pkg::BUS_LOAD
				&& !(line_valid[idx] && line_addr[idx] == blk) && !line_pending[idx]) begin
				exp_req.command = icache_pkg::BUS_LOAD;
				exp_req.address = blk;
				check_mem_req(mem_out, exp_req);
			end

			if (mem_out.command == icache_pkg::BUS_LOAD) begin
				if (mem_out.address[`ICACHE_OFFSET_BITS-1:0] != '0) begin
					report_error($sformatf("load address %h is not block aligned",
						mem_out.address));
				end
				if (block_in_flight(mem_out.address)) begin
					report_error($sformatf("load for block %h while it is in flight",
						mem_out.address));
				end
			end

			// prefetch stream after a redirect
			if (stream_active && !mispredict) begin
				idx = index_of(stream_next);
				if ((line_valid[idx] && line_addr[idx] == stream_next) || line_pending[idx]) begin
					exp_req.command = icache_pkg::BUS_NONE;
					exp_req.address = '0;
					check_mem_req(mem_out, exp_req);
					stream_next += BLOCK_BYTES;
					stream_events++;
				end else if (mem_out.command == icache_pkg::BUS_LOAD) begin
					exp_req.command = icache_pkg::BUS_LOAD;
					exp_req.address = stream_next;
					check_mem_req(mem_out, exp_req);
					if (accepted) begin
						stream_next += BLOCK_BYTES;
						stream_events++;
					end
				end
				if (stream_events >= STREAM_LEN) begin
					stream_active = 1'b0;
				end
			end
			if (mispredict && directed) begin
				stream_active = 1'b1;
				stream_next = align_block(target);
				stream_events = 0;
			end

			// mirror takes the effect of the coming edge
			if (mem_in.tag != '0) begin
				idx = index_of(txn_addr[mem_in.tag]);
				line_valid[idx] = 1'b1;
				line_addr[idx] = txn_addr[mem_in.tag];
				line_pending[idx] = 1'b0;
				txn_busy[mem_in.tag] = 1'b0;
				in_flight--;
			end
			if (accepted) begin
				idx = index_of(mem_out.address);
				line_pending[idx] = 1'b1;
				txn_busy[mem_in.response] = 1'b1;
				txn_addr[mem_in.response] = align_block(mem_out.address);
				in_flight++;
				if (in_flight > `ICACHE_PREFETCH_CREDITS + 1) begin
					report_error($sformatf("%0d loads in flight", in_flight));
				end
			end
		end
	end

	initial begin : stimulus
		seed = SEED;
		reset = 1'b1;
		req.address = '0;
		req.command = icache_pkg::BUS_NONE;
		mispredict = 1'b0;
		target = '0;
		directed = 1'b0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		for (int c = 0; c < STIM_CYCLES; c++) begin
			@(posedge clock);
			drive_random();
		end

		// redirects without demand traffic
		@(posedge clock);
		req.command <= icache_pkg::BUS_NONE;
		mispredict <= 1'b0;
		directed <= 1'b1;
		for (int n = 0; n < STREAM_TRIALS; n++) begin
			repeat (4) @(posedge clock);
			mispredict <= 1'b1;
			target <= window_addr();
			@(posedge clock);
			mispredict <= 1'b0;
			while (stream_active) begin
				@(posedge clock);
			end
		end

		repeat (2) @(posedge clock);
		$display("test passed");
		$finish;
	end

endmodule

// ==== tests/imem_model.sv ====
`include "icache_settings.svh"

module imem_model #(
	parameter int MAX_LATENCY = 8,
	parameter logic [31:0] SEED = 32'h487d
) (
	input logic clock,
	input logic reset,
	input icache_pkg::mem_req_t mem_out,
	input logic [`ICACHE_BLOCK_BITS-1:0] ret_data,
	output logic [`ICACHE_ADDR_BITS-1:0] ret_addr,
	output icache_pkg::mem_resp_t mem_in
);

	localparam int TAGS = 1 << `ICACHE_MEM_TAG_BITS;

	integer seed;
	logic accept_ok;
	logic [`ICACHE_MEM_TAG_BITS-1:0] free_tag;
	logic [`ICACHE_MEM_TAG_BITS-1:0] ret_tag;
	logic busy [TAGS];
	int wait_cycles [TAGS];
	logic [`ICACHE_ADDR_BITS-1:0] txn_addr [TAGS];

	initial seed = SEED;

	// lowest free tag, tag zero is never handed out
	always_comb begin
		free_tag = '0;
		for (int t = TAGS - 1; t > 0; t--) begin
			if (!busy[t]) begin
				free_tag = `ICACHE_MEM_TAG_BITS'(t);
			end
		end
	end

	assign mem_in.response = (mem_out.command == icache_pkg::BUS_LOAD && accept_ok) ?
		free_tag : '0;
	assign mem_in.tag = ret_tag;
	assign mem_in.data = (ret_tag != '0) ? ret_data : '0;

	always @(posedge clock) begin : step_model
		logic found;
		found = 1'b0;
		if (reset) begin
			ret_tag <= '0;
			ret_addr <= '0;
			accept_ok <= 1'b0;
			for (int t = 0; t < TAGS; t++) begin
				busy[t] <= 1'b0;
				wait_cycles[t] <= 0;
			end
		end else begin
			// roughly one cycle in four is back-pressure
			accept_ok <= ($random(seed) & 3) != 0;
			ret_tag <= '0;
			// tag is free again once its data went out
			if (ret_tag != '0) begin
				busy[ret_tag] <= 1'b0;
			end
			// one return per cycle, lowest ready tag first
			for (int t = 1; t < TAGS; t++) begin
				if (busy[t] && wait_cycles[t] != 0) begin
					wait_cycles[t] <= wait_cycles[t] - 1;
				end else if (busy[t] && !found && `ICACHE_MEM_TAG_BITS'(t) != ret_tag) begin
					found = 1'b1;
					ret_tag <= `ICACHE_MEM_TAG_BITS'(t);
					ret_addr <= txn_addr[t];
				end
			end
			if (mem_in.response != '0) begin
				busy[mem_in.response] <= 1'b1;
				wait_cycles[mem_in.response] <= $unsigned($random(seed)) % MAX_LATENCY;
				txn_addr[mem_in.response] <= mem_out.address;
			end
		end
	end

endmodule

// ==== src/icache.sv ====
`include "icache_settings.svh"

module icache (
	input logic clock,
	input logic reset,
	input icache_pkg::fetch_req_t req,
	input logic mispredict,
	input logic [`ICACHE_ADDR_BITS-1:0] target,
	input icache_pkg::mem_resp_t mem_in,
	output icache_pkg::mem_req_t mem_out,
	output icache_pkg::fetch_resp_t resp
);

	logic [`ICACHE_ADDR_BITS-1:0] pref_addr;
	logic pref_enable;
	logic pref_accepted;
	logic pref_skip;
	logic mem_accepted;
	logic tag_returned;

	icache_pkg::line_lookup_t demand_lookup;
	icache_pkg::line_lookup_t pref_lookup;
	icache_pkg::lookup_result_t demand_result;
	icache_pkg::lookup_result_t pref_result;

	logic issue_valid;
	logic [`ICACHE_INDEX_BITS-1:0] issue_index;
	logic [`ICACHE_MEM_TAG_BITS-1:0] issue_tag;

	icache_prefetch i_prefetch (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.target(target),
		.pref_accepted(pref_accepted),
		.pref_skip(pref_skip),
		.mem_accepted(mem_accepted),
		.tag_returned(tag_returned),
		.pref_addr(pref_addr),
		.pref_enable(pref_enable)
	);

	icache_controller i_controller (
		.req(req),
		.mispredict(mispredict),
		.pref_addr(pref_addr),
		.pref_enable(pref_enable),
		.demand_result(demand_result),
		.pref_result(pref_result),
		.mem_in(mem_in),
		.demand_lookup(demand_lookup),
		.pref_lookup(pref_lookup),
		.mem_out(mem_out),
		.resp(resp),
		.pref_accepted(pref_accepted),
		.pref_skip(pref_skip),
		.mem_accepted(mem_accepted),
		.issue_index(issue_index),
		.issue_valid(issue_valid),
		.issue_tag(issue_tag)
	);

	// line tag of the issued load comes from the bus address
	icachemem i_mem (
		.clock(clock),
		.reset(reset),
		.demand_lookup(demand_lookup),
		.pref_lookup(pref_lookup),
		.demand_result(demand_result),
		.pref_result(pref_result),
		.issue_valid(issue_valid),
		.issue_index(issue_index),
		.issue_tag(issue_tag),
		.issue_line_tag(mem_out.address[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS]),
		.mem_in(mem_in),
		.tag_returned(tag_returned)
	);

endmodule

// ==== src/icachemem.sv ====
`include "icache_settings.svh"

module icachemem (
	input logic clock,
	input logic reset,
	input icache_pkg::line_lookup_t demand_lookup,
	input icache_pkg::line_lookup_t pref_lookup,
	output icache_pkg::lookup_result_t demand_result,
	output icache_pkg::lookup_result_t pref_result,
	input logic issue_valid,
	input logic [`ICACHE_INDEX_BITS-1:0] issue_index,
	input logic [`ICACHE_MEM_TAG_BITS-1:0] issue_tag,
	input logic [`ICACHE_TAG_BITS-1:0] issue_line_tag,
	input icache_pkg::mem_resp_t mem_in,
	output logic tag_returned
);

	logic [`ICACHE_LINES-1:0] valid;
	logic [`ICACHE_LINES-1:0] pending;
	logic [`ICACHE_LINES-1:0] fill_hit;

	logic [`ICACHE_TAG_BITS-1:0] line_tag [`ICACHE_LINES];
	logic [`ICACHE_BLOCK_BITS-1:0] line_data [`ICACHE_LINES];

	// tag the line takes once its fill arrives
	logic [`ICACHE_TAG_BITS-1:0] fill_tag [`ICACHE_LINES];
	logic [`ICACHE_MEM_TAG_BITS-1:0] txn_tag [`ICACHE_LINES];

	assign tag_returned = (mem_in.tag != '0);

	// returning tag against every pending line, at most one matches
	always_comb begin
		for (int i = 0; i < `ICACHE_LINES; i++) begin
			fill_hit[i] = tag_returned && pending[i] && (txn_tag[i] == mem_in.tag);
		end
	end

	function automatic icache_pkg::lookup_result_t lookup(
		input icache_pkg::line_lookup_t req
	);
		icache_pkg::lookup_result_t result;
		result.hit = req.enable && valid[req.index] && (line_tag[req.index] == req.tag);
		result.pending = req.enable && pending[req.index];
		result.data = line_data[req.index];
		return result;
	endfunction

	// both ports read the same arrays combinationally
	always_comb begin
		demand_result = lookup(demand_lookup);
		pref_result = lookup(pref_lookup);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			pending <= '0;
		end else begin
			for (int i = 0; i < `ICACHE_LINES; i++) begin
				if (fill_hit[i]) begin
					valid[i] <= 1'b1;
					pending[i] <= 1'b0;
				end
			end
			// issue only goes to a line that is not pending, so no clash with a fill
			if (issue_valid) begin
				pending[issue_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `ICACHE_LINES; i++) begin
			if (fill_hit[i]) begin
				line_data[i] <= mem_in.data;
				line_tag[i] <= fill_tag[i];
			end
		end
		// the old block stays readable until the fill replaces it
		if (issue_valid) begin
			txn_tag[issue_index] <= issue_tag;
			fill_tag[issue_index] <= issue_line_tag;
		end
	end

endmodule

// ==== src/icache_controller.sv ====
`include "icache_settings.svh"

module icache_controller (
	input icache_pkg::fetch_req_t req,
	input logic mispredict,
	input logic [`ICACHE_ADDR_BITS-1:0] pref_addr,
	input logic pref_enable,
	input icache_pkg::lookup_result_t demand_result,
	input icache_pkg::lookup_result_t pref_result,
	input icache_pkg::mem_resp_t mem_in,
	output icache_pkg::line_lookup_t demand_lookup,
	output icache_pkg::line_lookup_t pref_lookup,
	output icache_pkg::mem_req_t mem_out,
	output icache_pkg::fetch_resp_t resp,
	output logic pref_accepted,
	output logic pref_skip,
	output logic mem_accepted,
	output logic [`ICACHE_INDEX_BITS-1:0] issue_index,
	output logic issue_valid,
	output logic [`ICACHE_MEM_TAG_BITS-1:0] issue_tag
);

	logic demand_miss;
	logic pref_wanted;
	logic send_demand;
	logic send_pref;

	// split an address into index and tag
	function automatic icache_pkg::line_lookup_t decode(
		input logic [`ICACHE_ADDR_BITS-1:0] addr,
		input logic enable
	);
		icache_pkg::line_lookup_t lookup;
		lookup.index = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		lookup.tag = addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
		lookup.enable = enable;
		return lookup;
	endfunction

	function automatic logic [`ICACHE_ADDR_BITS-1:0] block_align(
		input logic [`ICACHE_ADDR_BITS-1:0] addr
	);
		return {addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
	endfunction

	assign demand_lookup = decode(req.address, req.command == icache_pkg::BUS_LOAD);

	// the old stream is dropped while the pointer is redirected
	assign pref_lookup = decode(pref_addr, !mispredict);

	// a pending line is waited on, never requested twice
	assign demand_miss = demand_lookup.enable && !demand_result.hit && !demand_result.pending;
	assign pref_wanted = pref_enable && pref_lookup.enable
		&& !pref_result.hit && !pref_result.pending;

	// demand wins the bus over prefetch
	assign send_demand = demand_miss;
	assign send_pref = !demand_miss && pref_wanted;

	always_comb begin
		mem_out.command = icache_pkg::BUS_NONE;
		mem_out.address = '0;
		if (send_demand) begin
			mem_out.command = icache_pkg::BUS_LOAD;
			mem_out.address = block_align(req.address);
		end else if (send_pref) begin
			mem_out.command = icache_pkg::BUS_LOAD;
			mem_out.address = block_align(pref_addr);
		end
	end

	// nonzero response means memory took the load under that tag
	assign mem_accepted = (mem_out.command == icache_pkg::BUS_LOAD) && (mem_in.response != '0);
	assign pref_accepted = send_pref && mem_accepted;

	// block already here or on its way, so the stream moves on
	assign pref_skip = pref_lookup.enable && (pref_result.hit || pref_result.pending);

	// mark the line pending under the accept tag
	assign issue_valid = mem_accepted;
	assign issue_tag = mem_in.response;
	assign issue_index = send_demand ? demand_lookup.index : pref_lookup.index;

	// result straight from the demand lookup
	assign resp.data = demand_result.data;
	assign resp.valid = demand_result.hit && !mispredict;

endmodule

// ==== src/icache_prefetch.sv ====
`include "icache_settings.svh"

module icache_prefetch (
	input logic clock,
	input logic reset,
	input logic mispredict,
	input logic [`ICACHE_ADDR_BITS-1:0] target,
	input logic pref_accepted,
	input logic pref_skip,
	input logic mem_accepted,
	input logic tag_returned,
	output logic [`ICACHE_ADDR_BITS-1:0] pref_addr,
	output logic pref_enable
);

	// room for credits plus the one extra demand load
	localparam int COUNT_BITS = $clog2(`ICACHE_PREFETCH_CREDITS + 2);
	localparam logic [COUNT_BITS-1:0] CREDIT_LIMIT = COUNT_BITS'(`ICACHE_PREFETCH_CREDITS);
	localparam logic [`ICACHE_ADDR_BITS-1:0] BLOCK_STEP =
		`ICACHE_ADDR_BITS'(1) << `ICACHE_OFFSET_BITS;

	logic [`ICACHE_ADDR_BITS-1:0] stream_ptr;
	logic [`ICACHE_ADDR_BITS-1:0] target_block;
	logic [COUNT_BITS-1:0] in_flight;
	logic [COUNT_BITS-1:0] in_flight_next;
	logic active;

	assign target_block = {target[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
		{`ICACHE_OFFSET_BITS{1'b0}}};

	// one credit out per accept, one back per returning tag
	always_comb begin
		in_flight_next = in_flight;
		if (mem_accepted && !tag_returned) begin
			in_flight_next = in_flight + 1'b1;
		end else if (!mem_accepted && tag_returned && in_flight != '0) begin
			in_flight_next = in_flight - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			in_flight <= '0;
			active <= 1'b0;
		end else begin
			in_flight <= in_flight_next;
			// enabled from the first cycle out of reset
			active <= 1'b1;
		end
	end

	// stream pointer walks block by block
	always_ff @(posedge clock) begin
		if (reset) begin
			stream_ptr <= '0;
		end else if (mispredict) begin
			stream_ptr <= target_block;
		end else if (pref_accepted || pref_skip) begin
			stream_ptr <= stream_ptr + BLOCK_STEP;
		end
	end

	assign pref_addr = stream_ptr;
	assign pref_enable = active && (in_flight < CREDIT_LIMIT);

endmodule

// ==== src/icache_pkg.sv ====
`include "icache_settings.svh"

package icache_pkg;

	// command on the memory bus and from the processor
	typedef enum logic [1:0] {
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} bus_command_t;

	typedef struct packed {
		logic [`ICACHE_ADDR_BITS-1:0] address;
		bus_command_t command;
	} fetch_req_t;

	typedef struct packed {
		logic [`ICACHE_BLOCK_BITS-1:0] data;
		logic valid;
	} fetch_resp_t;

	typedef struct packed {
		bus_command_t command;
		logic [`ICACHE_ADDR_BITS-1:0] address;
	} mem_req_t;

	// response is the accept tag, tag is the returning one
	typedef struct packed {
		logic [`ICACHE_MEM_TAG_BITS-1:0] response;
		logic [`ICACHE_MEM_TAG_BITS-1:0] tag;
		logic [`ICACHE_BLOCK_BITS-1:0] data;
	} mem_resp_t;

	typedef struct packed {
		logic [`ICACHE_INDEX_BITS-1:0] index;
		logic [`ICACHE_TAG_BITS-1:0] tag;
		logic enable;
	} line_lookup_t;

	typedef struct packed {
		logic hit;
		logic pending;
		logic [`ICACHE_BLOCK_BITS-1:0] data;
	} lookup_result_t;

endpackage

// ==== include/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address and block geometry
`define ICACHE_ADDR_BITS 64
`define ICACHE_BLOCK_BITS 64
`define ICACHE_OFFSET_BITS 3

// direct mapped, one block per line
`define ICACHE_INDEX_BITS 5
`define ICACHE_LINES (1 << `ICACHE_INDEX_BITS)
`define ICACHE_TAG_BITS (`ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// memory transaction tag, zero means no transaction
`define ICACHE_MEM_TAG_BITS 4

// max prefetch loads in flight, a demand load may add one more
`define ICACHE_PREFETCH_CREDITS 8

`endif
